/* verilog/ipod_pkg.sv */
package ipod_pkg;

  // ====================================================================
  // Widths and limits
  // ====================================================================

  // Flash word address and data
  localparam int ADDR_W         = 23;
  localparam int WORD_W         = 32;

  // One audio sample per byte of a flash word
  localparam int SAMPLE_W       = 8;
  localparam int BYTES_PER_WORD = 4;

  // Playback divider, in CLK_50M cycles per sample
  localparam int DIV_W          = 16;
  localparam int MIN_SAMPLE_DIV = 16;
  localparam int MAX_SAMPLE_DIV = 65000;

  localparam int HEX_DIGITS     = 6;

  // ====================================================================
  // Keyboard command codes
  // ====================================================================

  localparam logic [7:0] ASCII_START      = 8'h45;
  localparam logic [7:0] ASCII_START_LC   = 8'h65;
  localparam logic [7:0] ASCII_STOP       = 8'h44;
  localparam logic [7:0] ASCII_STOP_LC    = 8'h64;
  localparam logic [7:0] ASCII_FWD        = 8'h46;
  localparam logic [7:0] ASCII_FWD_LC     = 8'h66;
  localparam logic [7:0] ASCII_BACK       = 8'h42;
  localparam logic [7:0] ASCII_BACK_LC    = 8'h62;
  localparam logic [7:0] ASCII_RESTART    = 8'h52;
  localparam logic [7:0] ASCII_RESTART_LC = 8'h72;

  // ====================================================================
  // Types
  // ====================================================================

  // Segments g..a, active low
  typedef logic [6:0] seg_t;

  typedef struct packed {
    logic              read;
    logic [ADDR_W-1:0] addr;
  } flash_req_t;

  typedef struct packed {
    logic              waitrequest;
    logic              readdatavalid;
    logic [WORD_W-1:0] readdata;
  } flash_rsp_t;

  typedef struct packed {
    logic playing;
    logic forward;
  } play_ctrl_t;

endpackage

/* verilog/key_command.sv */
`timescale 1ns/1ps

module key_command (
  input  logic                 CLK_50M,
  input  logic                 rst_n,
  input  logic [7:0]           kbd_ascii,
  input  logic                 kbd_ready,
  output ipod_pkg::play_ctrl_t play_ctrl,
  output logic                 restart
);

  import ipod_pkg::*;

  // Upper and lower case act alike
  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      play_ctrl.playing <= 1'b0;
      play_ctrl.forward <= 1'b1;
      restart           <= 1'b0;
    end
    else
    begin
      restart <= 1'b0;
      if (kbd_ready)
      begin
        case (kbd_ascii)
          ASCII_START, ASCII_START_LC:
            play_ctrl.playing <= 1'b1;
          ASCII_STOP, ASCII_STOP_LC:
            play_ctrl.playing <= 1'b0;
          ASCII_FWD, ASCII_FWD_LC:
            play_ctrl.forward <= 1'b1;
          ASCII_BACK, ASCII_BACK_LC:
            play_ctrl.forward <= 1'b0;
          // Play state and direction stay as they are
          ASCII_RESTART, ASCII_RESTART_LC:
            restart <= 1'b1;
          default:
            ;
        endcase
      end
    end
  end

  // Restart reaches the sequencer as a single-cycle pulse
  a_restart_pulse: assert property (
    @(posedge CLK_50M) disable iff (!rst_n)
    restart |=> !restart
  )
  else $error("restart held for more than one cycle");

endmodule

/* verilog/flash_reader.sv */
`timescale 1ns/1ps

module flash_reader (
  input  logic                        CLK_50M,
  input  logic                        rst_n,
  input  logic                        word_req,
  input  logic [ipod_pkg::ADDR_W-1:0] word_addr,
  input  ipod_pkg::flash_rsp_t        flash_rsp,
  output ipod_pkg::flash_req_t        flash_req,
  output logic                        word_valid,
  output logic [ipod_pkg::WORD_W-1:0] word_data
);

  import ipod_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,
    S_REQUEST,
    S_AWAIT_DATA
  } state_t;

  state_t            state;
  logic              read_q;
  logic [ADDR_W-1:0] addr_q;

  assign flash_req.read = read_q;
  assign flash_req.addr = addr_q;

  // ====================================================================
  // Read FSM, one word per request
  // ====================================================================

  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state      <= S_IDLE;
      read_q     <= 1'b0;
      addr_q     <= '0;
      word_valid <= 1'b0;
    end
    else
    begin
      word_valid <= 1'b0;
      case (state)
        S_IDLE:
        begin
          if (word_req)
          begin
            addr_q <= word_addr;
            read_q <= 1'b1;
            state  <= S_REQUEST;
          end
        end
        // Address held until the flash takes it
        S_REQUEST:
        begin
          if (!flash_rsp.waitrequest)
          begin
            read_q <= 1'b0;
            state  <= S_AWAIT_DATA;
          end
        end
        S_AWAIT_DATA:
        begin
          if (flash_rsp.readdatavalid)
          begin
            word_valid <= 1'b1;
            state      <= S_IDLE;
          end
        end
        default:
          state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge CLK_50M)
  begin
    if (state == S_AWAIT_DATA && flash_rsp.readdatavalid)
      word_data <= flash_rsp.readdata;
  end

  a_addr_hold: assert property (
    @(posedge CLK_50M) disable iff (!rst_n)
    flash_req.read && flash_rsp.waitrequest |=> flash_req.read && $stable(flash_req.addr)
  )
  else $error("flash read or address changed under waitrequest");

  // The sequencer keeps a single read outstanding
  a_req_idle: assert property (
    @(posedge CLK_50M) disable iff (!rst_n)
    word_req |-> state == S_IDLE
  )
  else $error("word request while a read is in progress");

endmodule

/* verilog/sample_sequencer.sv */
`timescale 1ns/1ps

module sample_sequencer #(
  parameter int unsigned LAST_ADDR = 32'h7FFFF
) (
  input  logic                          CLK_50M,
  input  logic                          rst_n,
  input  ipod_pkg::play_ctrl_t          play_ctrl,
  input  logic                          restart,
  input  logic                          sample_tick,
  input  logic                          word_valid,
  input  logic [ipod_pkg::WORD_W-1:0]   word_data,
  output logic                          word_req,
  output logic [ipod_pkg::ADDR_W-1:0]   word_addr,
  output logic [ipod_pkg::SAMPLE_W-1:0] audio_sample,
  output logic                          sample_strobe
);

  import ipod_pkg::*;

  // Sample position is the word address with the byte index below it
  localparam int BYTE_W = $clog2(BYTES_PER_WORD);
  localparam int POS_W  = ADDR_W + BYTE_W;
  localparam logic [POS_W-1:0] LAST_POS =
    POS_W'(LAST_ADDR * BYTES_PER_WORD + BYTES_PER_WORD - 1);

  logic [WORD_W-1:0] cur_word;
  logic [WORD_W-1:0] buf_word;
  logic [WORD_W-1:0] src_word;
  logic              cur_valid;
  logic              buf_valid;
  logic [POS_W-1:0]  last_pos;
  logic [POS_W-1:0]  next_pos;
  logic [POS_W-1:0]  flush_pos;
  logic [POS_W-1:0]  fetch_step;
  logic [ADDR_W-1:0] fetch_addr;
  logic [BYTE_W-1:0] byte_sel;
  logic              busy;
  logic              drop;
  logic              dir_q;
  logic              dir_change;
  logic              flush;
  logic              emit;
  logic              last_byte;

  // One step in the play direction, wrapping at both ends
  function automatic logic [POS_W-1:0] wrap_step(
    input logic [POS_W-1:0] v,
    input logic [POS_W-1:0] lim,
    input logic             fwd
  );
    if (fwd)
      return (v == lim) ? '0 : v + 1'b1;
    return (v == '0) ? lim : v - 1'b1;
  endfunction

  assign dir_change = play_ctrl.forward != dir_q;
  assign flush      = restart || dir_change;
  assign next_pos   = wrap_step(last_pos, LAST_POS, play_ctrl.forward);
  assign flush_pos  = restart ? (play_ctrl.forward ? '0 : LAST_POS) : next_pos;
  assign fetch_step = wrap_step(POS_W'(fetch_addr), POS_W'(LAST_ADDR), play_ctrl.forward);
  assign byte_sel   = next_pos[BYTE_W-1:0];
  assign last_byte  = play_ctrl.forward ? (byte_sel == BYTE_W'(BYTES_PER_WORD - 1))
                                        : (byte_sel == '0);
  assign src_word   = cur_valid ? cur_word : buf_word;

  // A tick with no word at hand is skipped
  assign emit = sample_tick && play_ctrl.playing && !flush && (cur_valid || buf_valid);

  // ====================================================================
  // Play position, prefetch and sample output
  // ====================================================================

  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cur_valid     <= 1'b0;
      buf_valid     <= 1'b0;
      busy          <= 1'b0;
      drop          <= 1'b0;
      dir_q         <= 1'b1;
      last_pos      <= LAST_POS;
      fetch_addr    <= '0;
      word_req      <= 1'b0;
      word_addr     <= '0;
      audio_sample  <= '0;
      sample_strobe <= 1'b0;
    end
    else
    begin
      dir_q         <= play_ctrl.forward;
      word_req      <= 1'b0;
      sample_strobe <= emit;
      if (word_valid)
        busy <= 1'b0;

      if (flush)
      begin
        // A read still in flight belongs to the old position
        cur_valid  <= 1'b0;
        buf_valid  <= 1'b0;
        drop       <= busy && !word_valid;
        fetch_addr <= flush_pos[POS_W-1:BYTE_W];
        if (restart)
          last_pos <= play_ctrl.forward ? LAST_POS : '0;
      end
      else
      begin
        if (word_valid)
        begin
          if (drop)
            drop <= 1'b0;
          else
            buf_valid <= 1'b1;
        end

        if (emit)
        begin
          audio_sample <= src_word[byte_sel*SAMPLE_W +: SAMPLE_W];
          last_pos     <= next_pos;
          cur_valid    <= !last_byte;
          if (!cur_valid)
            buf_valid <= 1'b0;
        end

        // Refill the prefetch slot as soon as it is free
        if (!busy && !buf_valid)
        begin
          word_req   <= 1'b1;
          busy       <= 1'b1;
          word_addr  <= fetch_addr;
          fetch_addr <= fetch_step[ADDR_W-1:0];
        end
      end
    end
  end

  always_ff @(posedge CLK_50M)
  begin
    if (!flush && emit && !cur_valid)
      cur_word <= buf_word;
    if (!flush && word_valid && !drop)
      buf_word <= word_data;
  end

  a_valid_in_flight: assert property (
    @(posedge CLK_50M) disable iff (!rst_n)
    word_valid |-> busy
  )
  else $error("flash word returned with no read outstanding");

endmodule

/* verilog/playback_rate.sv */
`timescale 1ns/1ps

module playback_rate #(
  parameter int unsigned DEFAULT_DIV  = 2272,
  parameter int unsigned SPEED_STEP   = 64,
  parameter int unsigned REPEAT_TICKS = 5000000
) (
  input  logic                       CLK_50M,
  input  logic                       rst_n,
  input  logic                       speed_up_n,
  input  logic                       speed_down_n,
  input  logic                       speed_reset_n,
  output logic [ipod_pkg::DIV_W-1:0] div_count,
  output logic                       sample_tick
);

  import ipod_pkg::*;

  localparam int RPT_W   = $clog2(REPEAT_TICKS + 1);
  localparam int K_UP    = 0;
  localparam int K_DOWN  = 1;
  localparam int K_RESET = 2;

  logic [2:0]       key_n;
  logic [2:0]       key_event;
  logic [DIV_W-1:0] tick_cnt;
  logic [DIV_W-1:0] period;

  assign key_n = {speed_reset_n, speed_down_n, speed_up_n};

  // ====================================================================
  // Key synchronizers and repeat limiting
  // ====================================================================

  for (genvar k = 0; k < 3; k++)
  begin : g_key
    logic [1:0]       sync_n;
    logic             pressed;
    logic             held_q;
    logic             press;
    logic             rpt_hit;
    logic [RPT_W-1:0] rpt_cnt;

    assign pressed      = !sync_n[1];
    assign press        = pressed && !held_q;
    assign rpt_hit      = pressed && (rpt_cnt == RPT_W'(REPEAT_TICKS - 1));
    assign key_event[k] = press || rpt_hit;

    always_ff @(posedge CLK_50M or negedge rst_n)
    begin
      if (!rst_n)
      begin
        sync_n  <= 2'b11;
        held_q  <= 1'b0;
        rpt_cnt <= '0;
      end
      else
      begin
        sync_n <= {sync_n[0], key_n[k]};
        held_q <= pressed;
        // Held key repeats every REPEAT_TICKS cycles after the press
        if (!pressed || press || rpt_hit)
          rpt_cnt <= '0;
        else
          rpt_cnt <= rpt_cnt + 1'b1;
      end
    end
  end

  // ====================================================================
  // Divider count and sample tick
  // ====================================================================

  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
      div_count <= DIV_W'(DEFAULT_DIV);
    else if (key_event[K_RESET])
      div_count <= DIV_W'(DEFAULT_DIV);
    else if (key_event[K_UP])
    begin
      if (div_count < MIN_SAMPLE_DIV + SPEED_STEP)
        div_count <= DIV_W'(MIN_SAMPLE_DIV);
      else
        div_count <= div_count - DIV_W'(SPEED_STEP);
    end
    else if (key_event[K_DOWN])
    begin
      if (div_count > MAX_SAMPLE_DIV - SPEED_STEP)
        div_count <= DIV_W'(MAX_SAMPLE_DIV);
      else
        div_count <= div_count + DIV_W'(SPEED_STEP);
    end
  end

  // New count is picked up only at a wrap
  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      tick_cnt    <= '0;
      period      <= DIV_W'(DEFAULT_DIV);
      sample_tick <= 1'b0;
    end
    else if (tick_cnt == period - 1'b1)
    begin
      tick_cnt    <= '0;
      period      <= div_count;
      sample_tick <= 1'b1;
    end
    else
    begin
      tick_cnt    <= tick_cnt + 1'b1;
      sample_tick <= 1'b0;
    end
  end

  a_div_range: assert property (
    @(posedge CLK_50M) disable iff (!rst_n)
    div_count >= MIN_SAMPLE_DIV && div_count <= MAX_SAMPLE_DIV
  )
  else $error("divider count out of range");

endmodule

/* verilog/hex_display.sv */
`timescale 1ns/1ps

module hex_display (
  input  logic                                      CLK_50M,
  input  logic                                      rst_n,
  input  logic [ipod_pkg::DIV_W-1:0]                div_count,
  output ipod_pkg::seg_t [ipod_pkg::HEX_DIGITS-1:0] hex
);

  import ipod_pkg::*;

  logic [4*HEX_DIGITS-1:0] nibbles;

  // Standard 0-F glyphs, low segment on
  function automatic seg_t seg_decode(input logic [3:0] n);
    case (n)
      4'h0: return 7'b1000000;
      4'h1: return 7'b1111001;
      4'h2: return 7'b0100100;
      4'h3: return 7'b0110000;
      4'h4: return 7'b0011001;
      4'h5: return 7'b0010010;
      4'h6: return 7'b0000010;
      4'h7: return 7'b1111000;
      4'h8: return 7'b0000000;
      4'h9: return 7'b0010000;
      4'hA: return 7'b0001000;
      4'hB: return 7'b0000011;
      4'hC: return 7'b1000110;
      4'hD: return 7'b0100001;
      4'hE: return 7'b0000110;
      default: return 7'b0001110;
    endcase
  endfunction

  // Digit 0 is the least significant nibble
  assign nibbles = (4*HEX_DIGITS)'(div_count);

  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
      hex <= '1;
    else
    begin
      for (int i = 0; i < HEX_DIGITS; i++)
        hex[i] <= seg_decode(nibbles[4*i +: 4]);
    end
  end

endmodule

/* verilog/ipod_player.sv */
`timescale 1ns/1ps

module ipod_player #(
  parameter int unsigned DEFAULT_DIV  = 2272,
  parameter int unsigned SPEED_STEP   = 64,
  parameter int unsigned REPEAT_TICKS = 5000000,
  parameter int unsigned LAST_ADDR    = 32'h7FFFF
) (
  input  logic                                      CLK_50M,
  input  logic                                      rst_n,
  input  logic [7:0]                                kbd_ascii,
  input  logic                                      kbd_ready,
  input  logic                                      speed_up_n,
  input  logic                                      speed_down_n,
  input  logic                                      speed_reset_n,
  output ipod_pkg::flash_req_t                      flash_req,
  input  ipod_pkg::flash_rsp_t                      flash_rsp,
  output logic [ipod_pkg::SAMPLE_W-1:0]             audio_sample,
  output logic                                      sample_strobe,
  output logic                                      playing,
  output ipod_pkg::seg_t [ipod_pkg::HEX_DIGITS-1:0] hex
);

  import ipod_pkg::*;

  play_ctrl_t        play_ctrl;
  logic              restart;
  logic              sample_tick;
  logic [DIV_W-1:0]  div_count;
  logic              word_req;
  logic [ADDR_W-1:0] word_addr;
  logic              word_valid;
  logic [WORD_W-1:0] word_data;

  assign playing = play_ctrl.playing;

  key_command u_key_command (
    .CLK_50M   (CLK_50M),
    .rst_n     (rst_n),
    .kbd_ascii (kbd_ascii),
    .kbd_ready (kbd_ready),
    .play_ctrl (play_ctrl),
    .restart   (restart)
  );

  playback_rate #(
    .DEFAULT_DIV  (DEFAULT_DIV),
    .SPEED_STEP   (SPEED_STEP),
    .REPEAT_TICKS (REPEAT_TICKS)
  ) u_playback_rate (
    .CLK_50M       (CLK_50M),
    .rst_n         (rst_n),
    .speed_up_n    (speed_up_n),
    .speed_down_n  (speed_down_n),
    .speed_reset_n (speed_reset_n),
    .div_count     (div_count),
    .sample_tick   (sample_tick)
  );

  sample_sequencer #(
    .LAST_ADDR (LAST_ADDR)
  ) u_sample_sequencer (
    .CLK_50M       (CLK_50M),
    .rst_n         (rst_n),
    .play_ctrl     (play_ctrl),
    .restart       (restart),
    .sample_tick   (sample_tick),
    .word_valid    (word_valid),
    .word_data     (word_data),
    .word_req      (word_req),
    .word_addr     (word_addr),
    .audio_sample  (audio_sample),
    .sample_strobe (sample_strobe)
  );

  flash_reader u_flash_reader (
    .CLK_50M    (CLK_50M),
    .rst_n      (rst_n),
    .word_req   (word_req),
    .word_addr  (word_addr),
    .flash_rsp  (flash_rsp),
    .flash_req  (flash_req),
    .word_valid (word_valid),
    .word_data  (word_data)
  );

  hex_display u_hex_display (
    .CLK_50M   (CLK_50M),
    .rst_n     (rst_n),
    .div_count (div_count),
    .hex       (hex)
  );

endmodule

/* testbench/flash_model.sv */
`timescale 1ns/1ps

module flash_model (
  input  logic                 CLK_50M,
  input  logic                 rst_n,
  input  ipod_pkg::flash_req_t flash_req,
  output ipod_pkg::flash_rsp_t flash_rsp
);

  import ipod_pkg::*;

  typedef enum logic [1:0] {
    M_IDLE,
    M_WAIT,
    M_ACCEPT,
    M_LATENCY
  } mstate_t;

  mstate_t           mstate;
  int unsigned       wait_left;
  int unsigned       lat_left;
  logic [ADDR_W-1:0] addr_q;

  // Byte k of the word at address a holds 4a+k, modulo 256
  function automatic logic [WORD_W-1:0] word_at(input logic [ADDR_W-1:0] a);
    logic [WORD_W-1:0] w;
    for (int k = 0; k < BYTES_PER_WORD; k++)
      w[k*SAMPLE_W +: SAMPLE_W] = SAMPLE_W'((BYTES_PER_WORD * int'(a) + k) % 256);
    return w;
  endfunction

  // ====================================================================
  // Bus responder, outputs change on the falling edge
  // ====================================================================

  always @(negedge CLK_50M or negedge rst_n)
  begin
    int unsigned draw;
    if (!rst_n)
    begin
      mstate                  <= M_IDLE;
      wait_left               <= 0;
      lat_left                <= 0;
      addr_q                  <= '0;
      flash_rsp.waitrequest   <= 1'b1;
      flash_rsp.readdatavalid <= 1'b0;
      flash_rsp.readdata      <= '0;
    end
    else
    begin
      flash_rsp.readdatavalid <= 1'b0;
      case (mstate)
        M_IDLE:
        begin
          if (flash_req.read)
          begin
            addr_q <= flash_req.addr;
            // 0 to 3 wait states
            draw = $urandom % 4;
            if (draw == 0)
            begin
              flash_rsp.waitrequest <= 1'b0;
              mstate                <= M_ACCEPT;
            end
            else
            begin
              wait_left <= draw - 1;
              mstate    <= M_WAIT;
            end
          end
        end
        M_WAIT:
        begin
          if (wait_left == 0)
          begin
            flash_rsp.waitrequest <= 1'b0;
            mstate                <= M_ACCEPT;
          end
          else
            wait_left <= wait_left - 1;
        end
        // Read taken on the last rising edge, data follows 1 to 4 cycles later
        M_ACCEPT:
        begin
          flash_rsp.waitrequest <= 1'b1;
          draw = $urandom % 4;
          if (draw == 0)
          begin
            flash_rsp.readdatavalid <= 1'b1;
            flash_rsp.readdata      <= word_at(addr_q);
            mstate                  <= M_IDLE;
          end
          else
          begin
            lat_left <= draw - 1;
            mstate   <= M_LATENCY;
          end
        end
        default:
        begin
          if (lat_left == 0)
          begin
            flash_rsp.readdatavalid <= 1'b1;
            flash_rsp.readdata      <= word_at(addr_q);
            mstate                  <= M_IDLE;
          end
          else
            lat_left <= lat_left - 1;
        end
      endcase
    end
  end

endmodule

/* testbench/tb_ipod_player.sv */
`timescale 1ns/1ps

module tb_ipod_player;

  import ipod_pkg::*;

  localparam int unsigned DEFAULT_DIV  = 40;
  localparam int unsigned SPEED_STEP   = 4;
  localparam int unsigned REPEAT_TICKS = 64;
  localparam int unsigned LAST_ADDR    = 7;

  // Sample positions run 0..LAST_SAMPLE, four per word
  localparam int LAST_SAMPLE  = (LAST_ADDR + 1) * BYTES_PER_WORD - 1;
  localparam int STROBE_LIMIT = 200;
  localparam int KEY_UP       = 0;
  localparam int KEY_DOWN     = 1;
  localparam int KEY_RESET    = 2;

  logic                  CLK_50M;
  logic                  rst_n;
  logic [7:0]            kbd_ascii;
  logic                  kbd_ready;
  logic                  speed_up_n;
  logic                  speed_down_n;
  logic                  speed_reset_n;
  flash_req_t            flash_req;
  flash_rsp_t            flash_rsp;
  logic [SAMPLE_W-1:0]   audio_sample;
  logic                  sample_strobe;
  logic                  playing;
  seg_t [HEX_DIGITS-1:0] hex;

  int error_count;
  int timeout_count;
  int play_pos;

  always #10 CLK_50M = ~CLK_50M;

  ipod_player #(
    .DEFAULT_DIV  (DEFAULT_DIV),
    .SPEED_STEP   (SPEED_STEP),
    .REPEAT_TICKS (REPEAT_TICKS),
    .LAST_ADDR    (LAST_ADDR)
  ) dut0 (
    .CLK_50M       (CLK_50M),
    .rst_n         (rst_n),
    .kbd_ascii     (kbd_ascii),
    .kbd_ready     (kbd_ready),
    .speed_up_n    (speed_up_n),
    .speed_down_n  (speed_down_n),
    .speed_reset_n (speed_reset_n),
    .flash_req     (flash_req),
    .flash_rsp     (flash_rsp),
    .audio_sample  (audio_sample),
    .sample_strobe (sample_strobe),
    .playing       (playing),
    .hex           (hex)
  );

  flash_model flash0 (
    .CLK_50M   (CLK_50M),
    .rst_n     (rst_n),
    .flash_req (flash_req),
    .flash_rsp (flash_rsp)
  );

  // ====================================================================
  // Reference rules
  // ====================================================================

  function automatic int step_pos(input int p, input bit fwd);
    if (fwd)
      return (p + 1) % (LAST_SAMPLE + 1);
    return (p + LAST_SAMPLE) % (LAST_SAMPLE + 1);
  endfunction

  function automatic logic [SAMPLE_W-1:0] sample_of(input int p);
    return SAMPLE_W'(p % 256);
  endfunction

  // Lit segments, gfedcba
  function automatic logic [6:0] lit_segments(input logic [3:0] n);
    case (n)
      4'h0: return 7'h3F;
      4'h1: return 7'h06;
      4'h2: return 7'h5B;
      4'h3: return 7'h4F;
      4'h4: return 7'h66;
      4'h5: return 7'h6D;
      4'h6: return 7'h7D;
      4'h7: return 7'h07;
      4'h8: return 7'h7F;
      4'h9: return 7'h6F;
      4'hA: return 7'h77;
      4'hB: return 7'h7C;
      4'hC: return 7'h39;
      4'hD: return 7'h5E;
      4'hE: return 7'h79;
      default: return 7'h71;
    endcase
  endfunction

  function automatic logic [7*HEX_DIGITS-1:0] display_of(input logic [23:0] v);
    logic [7*HEX_DIGITS-1:0] segs;
    for (int i = 0; i < HEX_DIGITS; i++)
      segs[7*i +: 7] = ~lit_segments(v[4*i +: 4]);
    return segs;
  endfunction

  // ====================================================================
  // Driving, waiting and checking
  // ====================================================================

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected)
    begin
      error_count++;
      $display("** Error: %s = 0x%0h, expected 0x%0h at %0t", name, actual, expected, $time);
    end
  endtask

  task automatic send_key(input logic [7:0] code);
    kbd_ascii = code;
    kbd_ready = 1'b1;
    @(negedge CLK_50M);
    kbd_ready = 1'b0;
  endtask

  task automatic hold_speed_key(input int key, input int cycles);
    case (key)
      KEY_UP:   speed_up_n = 1'b0;
      KEY_DOWN: speed_down_n = 1'b0;
      default:  speed_reset_n = 1'b0;
    endcase
    repeat (cycles) @(negedge CLK_50M);
    speed_up_n    = 1'b1;
    speed_down_n  = 1'b1;
    speed_reset_n = 1'b1;
    // Release has to pass the two-stage synchronizer
    repeat (3) @(negedge CLK_50M);
  endtask

  task automatic wait_strobe(input int limit, output logic [SAMPLE_W-1:0] value);
    int cycles;
    cycles = 0;
    value  = 'x;
    do
    begin
      @(negedge CLK_50M);
      cycles++;
    end
    while (!sample_strobe && cycles < limit);
    if (sample_strobe)
      value = audio_sample;
    else
    begin
      timeout_count++;
      $display("Timeout: no sample strobe within %0d cycles at %0t", limit, $time);
    end
  endtask

  task automatic wait_display(input logic [23:0] value, input int limit);
    int cycles;
    cycles = 0;
    while (hex !== display_of(value) && cycles < limit)
    begin
      @(negedge CLK_50M);
      cycles++;
    end
    check_value("hex", hex, display_of(value));
  endtask

  // First strobe must carry first_pos, the rest follow in play direction
  task automatic play_check(input int first_pos, input int count, input bit fwd);
    logic [SAMPLE_W-1:0] got;
    play_pos = first_pos;
    for (int i = 0; i < count; i++)
    begin
      if (i > 0)
        play_pos = step_pos(play_pos, fwd);
      wait_strobe(STROBE_LIMIT, got);
      check_value("audio_sample", got, sample_of(play_pos));
    end
  endtask

  // ====================================================================
  // Tests
  // ====================================================================

  task automatic test_reset();
    check_value("sample_strobe", sample_strobe, 0);
    check_value("flash_req.read", flash_req.read, 0);
    check_value("playing", playing, 0);
    @(negedge CLK_50M);
    check_value("audio_sample", audio_sample, 0);
    check_value("hex", hex, display_of(24'h000028));
  endtask

  task automatic test_forward();
    send_key(ASCII_START);
    check_value("playing", playing, 1);
    play_check(0, 40, 1'b1);
  endtask

  task automatic test_backward_restart();
    send_key(ASCII_BACK_LC);
    play_check(step_pos(play_pos, 1'b0), 12, 1'b0);
    send_key(ASCII_RESTART);
    play_check(LAST_SAMPLE, 4, 1'b0);
    send_key(ASCII_FWD);
    send_key(ASCII_RESTART_LC);
    play_check(0, 4, 1'b1);
  endtask

  task automatic test_stop_resume();
    logic [SAMPLE_W-1:0] held;
    int                  cycles;
    held = audio_sample;
    send_key(ASCII_STOP);
    check_value("playing", playing, 0);
    cycles = 0;
    while (cycles < 200)
    begin
      @(negedge CLK_50M);
      cycles++;
      if (sample_strobe)
      begin
        error_count++;
        $display("Sample strobe seen while playback is stopped at %0t", $time);
      end
    end
    check_value("audio_sample", audio_sample, held);
    send_key(ASCII_START_LC);
    play_check(step_pos(play_pos, 1'b1), 8, 1'b1);
  endtask

  task automatic test_speed_keys();
    logic [SAMPLE_W-1:0] got;
    bit                  keys_done;
    keys_done = 1'b0;
    fork
      begin
        hold_speed_key(KEY_DOWN, 20);
        wait_display(24'h00002C, 20);
        hold_speed_key(KEY_UP, 20);
        wait_display(24'h000028, 20);
        // Press plus nine repeats, well short of an eleventh
        hold_speed_key(KEY_UP, 3 + 9 * REPEAT_TICKS + 20);
        wait_display(24'h000010, 20);
        hold_speed_key(KEY_RESET, 20);
        wait_display(24'h000028, 20);
        keys_done = 1'b1;
      end
      begin
        // Samples keep their order while the rate changes
        while (!keys_done)
        begin
          play_pos = step_pos(play_pos, 1'b1);
          wait_strobe(STROBE_LIMIT, got);
          check_value("audio_sample", got, sample_of(play_pos));
        end
      end
    join
    play_check(step_pos(play_pos, 1'b1), 20, 1'b1);
  endtask

  initial
  begin
    void'($urandom(9));
    error_count   = 0;
    timeout_count = 0;
    play_pos      = LAST_SAMPLE;
    CLK_50M       = 1'b0;
    rst_n         = 1'b0;
    kbd_ascii     = 8'h00;
    kbd_ready     = 1'b0;
    speed_up_n    = 1'b1;
    speed_down_n  = 1'b1;
    speed_reset_n = 1'b1;

    repeat (4) @(posedge CLK_50M);
    @(negedge CLK_50M);
    rst_n = 1'b1;

    test_reset();
    test_forward();
    test_backward_restart();
    test_stop_resume();
    test_speed_keys();

    $display("Summary: %0d value errors, %0d timeouts", error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

/* ipod_player.f */
verilog/ipod_pkg.sv
verilog/key_command.sv
verilog/flash_reader.sv
verilog/sample_sequencer.sv
verilog/playback_rate.sv
verilog/hex_display.sv
verilog/ipod_player.sv
testbench/flash_model.sv
testbench/tb_ipod_player.sv

/* run_sim.sh */
#!/bin/sh
# Compile the testbench and the player with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_ipod_player --Mdir obj_dir -o sim_tb \
  -f ipod_player.f \
  && ./obj_dir/sim_tb | tee /dev/stderr | grep -q "Verification passed" \
  && echo "Simulation run: PASS" \
  || { echo "Simulation run: FAIL"; exit 1; }
